// File: cpu_testdata.txt
# tags: P word | D addr word | S addr word (expected stores, in order)
# O index flag (overflow after the index-th executed instruction) | E final pc; all hex
P 44100007 P 44280003 P 40308800 P 14300001   # movi r1, movi r2, add r3, swi r3
P 40408801 P 14400002                         # sub r4, swi r4
P 40510c02 P 40609004 P 40719003              # and r5, or r6, xor r7
P 14500003 P 14600004 P 14700005              # swi r5 r6 r7
P 5080fffd P 58907ff0 P 40a09008 P 40b12009   # addi -3, ori, slli 4, srli 8
P 14800006 P 14900007 P 14a00008 P 14b00009   # swi r8 r9 r10 r11
P 04c08019 P 40d60400 P 14d08003 P 14d57ff0   # lwi, add, swi, swi with negative offset
P 58e00007 P 4ce08002 P 14100030              # ori r14, beq taken, skipped swi
P 4ce0c002 P 14e00031 P 48000003              # bne not taken, swi, j +3
P 14100032 P 14100033                         # skipped by the jump
P 44f7ffff P 40f7b008 P 4107bc00 P 51108001   # build 7ffff000, add overflows, addi clears
P 15000040 P 15100041 P 48000000              # swi r16, swi r17, j 0 holds the pc
D 020 11110000
S 001 fff8000a S 002 00080004 S 003 fff80002
S 004 00080007 S 005 fff0000e S 006 00000004
S 007 00007ff0 S 008 00000070 S 009 00fff800
S 00a 11110007 S 060 11110007 S 031 00000007
S 040 ffffe000 S 041 00000008
O 02 0 O 04 0 O 1f 1 O 20 0
E 026

// File: filelist.f
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
alu.sv
regfile.sv
controller.sv
operand_select.sv
pc_unit.sv
cpu_top.sv
tb_cpu_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu_top
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) cpu_testdata.txt
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx '=== PASS ===' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_cpu_top.sv
`timescale 1ns/1ns

module tb_cpu_top;
	import cpu_isa_pkg::*;

	localparam int IM_ADDR_W = 10;
	localparam int DM_ADDR_W = 12;
	localparam int RESET_CYCLES = 2;

	typedef logic [IM_ADDR_W-1:0] im_addr_t;
	typedef logic [DM_ADDR_W-1:0] dm_addr_t;

	logic     enable_memaccess = 1'b0;
	logic     rst;
	instr_t   instruction;
	logic     im_enable;
	im_addr_t im_address;
	logic     dm_read;
	logic     dm_write;
	dm_addr_t dm_address;
	word_t    dm_in;
	word_t    dm_out;
	logic     alu_overflow;
	logic     read_held = 1'b0;

	instr_t imem [2**IM_ADDR_W];
	word_t  dmem [2**DM_ADDR_W];

	// expected results consumed in order
	dm_addr_t exp_store_addr [$];
	word_t    exp_store_data [$];
	int       exp_ov_index [$];
	logic     exp_ov_flag [$];
	im_addr_t final_pc;
	int       prog_len;
	int       cycle_limit;
	int       mismatch_count;
	int       fault_count;

	always #10 enable_memaccess = ~enable_memaccess;

	// both memories answer within the cycle
	assign instruction = imem[im_address];
	// load data is only good from the read strobe through writeback
	assign dm_out = (dm_read || read_held) ? dmem[dm_address] : ~dmem[dm_address];

	always @(posedge enable_memaccess) begin
		read_held <= dm_read;
	end

	cpu_top #(.IM_ADDR_W(IM_ADDR_W), .DM_ADDR_W(DM_ADDR_W)) u_cpu_top (
		.enable_memaccess(enable_memaccess), .rst(rst), .instruction(instruction),
		.im_enable(im_enable), .im_address(im_address),
		.dm_read(dm_read), .dm_write(dm_write), .dm_address(dm_address),
		.dm_in(dm_in), .dm_out(dm_out), .alu_overflow(alu_overflow)
	);

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_addr(input string name, input dm_addr_t expected,
			input dm_addr_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_idle_outputs(input string when);
		check_flag({"dm_read ", when}, 1'b0, dm_read);
		check_flag({"dm_write ", when}, 1'b0, dm_write);
		check_flag({"alu_overflow ", when}, 1'b0, alu_overflow);
	endtask

	task automatic fill_memories();
		for (int i = 0; i < 2**IM_ADDR_W; i++) begin
			// opcode 3f is unused, so a stray fetch is a no-op
			imem[IM_ADDR_W'(i)] = {1'b0, 6'h3f, 25'(i)};
		end
		for (int i = 0; i < 2**DM_ADDR_W; i++) begin
			dmem[DM_ADDR_W'(i)] = 32'hc0de0000 ^ word_t'(i);
		end
	endtask

	task automatic load_testdata();
		int fd;
		int n;
		logic [7:0] tag;
		word_t a;
		word_t d;
		logic [8*160-1:0] rest;
		fd = $fopen("cpu_testdata.txt", "r");
		if (fd == 0) begin
			fault_count++;
			$display("cannot open cpu_testdata.txt");
			return;
		end
		while ($fscanf(fd, " %c", tag) == 1) begin
			case (tag)
				"#": n = $fgets(rest, fd);
				"P": begin
					n = $fscanf(fd, " %h", d);
					imem[IM_ADDR_W'(prog_len)] = d;
					prog_len++;
				end
				"D": begin
					n = $fscanf(fd, " %h %h", a, d);
					dmem[DM_ADDR_W'(a)] = d;
				end
				"S": begin
					n = $fscanf(fd, " %h %h", a, d);
					exp_store_addr.push_back(DM_ADDR_W'(a));
					exp_store_data.push_back(d);
				end
				"O": begin
					n = $fscanf(fd, " %h %h", a, d);
					exp_ov_index.push_back(int'(a));
					exp_ov_flag.push_back(d[0]);
				end
				"E": begin
					n = $fscanf(fd, " %h", a);
					final_pc = IM_ADDR_W'(a);
				end
				default: begin
					fault_count++;
					$display("unknown record tag %c in cpu_testdata.txt", tag);
				end
			endcase
		end
		$fclose(fd);
	endtask

	// every instruction takes five cycles with fetch as phase 0
	task automatic run_program();
		int cycles;
		int phase;
		int instr_idx;
		int store_no;
		bit reached;
		cycles = 0;
		phase = 0;
		instr_idx = -1;
		store_no = 0;
		reached = 1'b0;
		while (!reached && cycles < cycle_limit) begin
			@(negedge enable_memaccess);
			cycles++;
			if (cycles == 1) begin
				check_flag("first fetch enable", 1'b1, im_enable);
				check_word("first fetch address", '0, word_t'(im_address));
				check_idle_outputs("after reset");
			end
			if (im_enable) begin
				phase = 0;
				instr_idx++;
				reached = (im_address == final_pc);
			end else begin
				phase++;
			end
			if (phase != 3 && (dm_read || dm_write)) begin
				fault_count++;
				$display("memory strobe outside memaccess in instruction %0d", instr_idx);
			end
			if (phase == 3 && exp_ov_index.size() > 0 && exp_ov_index[0] == instr_idx) begin
				check_flag($sformatf("overflow after instruction %0d", instr_idx),
					exp_ov_flag[0], alu_overflow);
				exp_ov_index.delete(0);
				exp_ov_flag.delete(0);
			end
			if (dm_write) begin
				if (exp_store_addr.size() == 0) begin
					fault_count++;
					$display("unexpected store of %h to address %h", dm_in, dm_address);
				end else begin
					check_addr($sformatf("store %0d address", store_no),
						exp_store_addr[0], dm_address);
					check_word($sformatf("store %0d data", store_no),
						exp_store_data[0], dm_in);
					exp_store_addr.delete(0);
					exp_store_data.delete(0);
				end
				store_no++;
				dmem[dm_address] = dm_in;
			end
		end
		if (!reached) begin
			fault_count++;
			$display("timeout: program did not reach its final pc");
		end
	endtask

	initial begin
		rst = 1'b1;
		prog_len = 0;
		mismatch_count = 0;
		fault_count = 0;
		final_pc = '0;
		fill_memories();
		load_testdata();
		cycle_limit = 5 * prog_len * 2 + RESET_CYCLES;
		@(posedge enable_memaccess);
		@(negedge enable_memaccess);
		check_idle_outputs("during reset");
		check_flag("im_enable during reset", 1'b0, im_enable);
		repeat (RESET_CYCLES - 1) @(posedge enable_memaccess);
		rst <= 1'b0;
		if (prog_len > 0) begin
			run_program();
		end else begin
			fault_count++;
			$display("no program words found in cpu_testdata.txt");
		end
		foreach (exp_store_addr[i]) begin
			fault_count++;
			$display("expected store to address %h never happened", exp_store_addr[i]);
		end
		foreach (exp_ov_index[i]) begin
			fault_count++;
			$display("overflow check after instruction %0d never reached", exp_ov_index[i]);
		end
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
		if (mismatch_count == 0 && fault_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ns

module cpu_top #(
	parameter int IM_ADDR_W = 10,
	parameter int DM_ADDR_W = 12
) (
	input  logic                 enable_memaccess,
	input  logic                 rst,
	input  cpu_isa_pkg::instr_t  instruction,
	output logic                 im_enable,
	output logic [IM_ADDR_W-1:0] im_address,
	output logic                 dm_read,
	output logic                 dm_write,
	output logic [DM_ADDR_W-1:0] dm_address,
	output cpu_isa_pkg::word_t   dm_in,
	input  cpu_isa_pkg::word_t   dm_out,
	output logic                 alu_overflow
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic        fetch_en;
	logic        execute_en;
	logic        memaccess_en;
	logic        writeback_en;
	exec_ctrl_t  ctrl;
	imm_fields_t imms;
	reg_addr_t   ra_addr;
	reg_addr_t   rb_addr;
	reg_addr_t   rt_addr;
	pc_sel_e     pc_sel;
	word_t       ra_data;
	word_t       rb_data;
	word_t       rt_data;
	word_t       alu_src2;
	word_t       alu_result;
	word_t       wb_data;
	logic        alu_zero;

	assign im_enable = fetch_en;
	assign dm_read = memaccess_en & ctrl.dm_read;
	assign dm_write = memaccess_en & ctrl.dm_write;
	// address stays latched through writeback, so read data may follow it
	assign dm_address = alu_result[DM_ADDR_W-1:0];
	assign dm_in = rt_data;

	controller #(.IM_ADDR_W(IM_ADDR_W)) u_controller (
		.enable_memaccess(enable_memaccess), .rst(rst),
		.instruction(instruction), .alu_zero(alu_zero),
		.fetch_en(fetch_en), .decode_en(), .execute_en(execute_en),
		.memaccess_en(memaccess_en), .writeback_en(writeback_en),
		.ctrl(ctrl), .imms(imms),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.pc_sel(pc_sel)
	);

	regfile u_regfile (
		.enable_memaccess(enable_memaccess), .rst(rst),
		.writeback_en(writeback_en), .reg_write(ctrl.reg_write),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.wb_data(wb_data),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data)
	);

	operand_select u_operand_select (
		.rb_data(rb_data), .imms(imms), .imm_sel(ctrl.imm_sel),
		.src2_sel(ctrl.src2_sel), .wb_sel(ctrl.wb_sel),
		.alu_result(alu_result), .dm_out(dm_out),
		.alu_src2(alu_src2), .wb_data(wb_data)
	);

	alu #(.DM_ADDR_W(DM_ADDR_W)) u_alu (
		.enable_memaccess(enable_memaccess), .rst(rst), .execute_en(execute_en),
		.alu_op(ctrl.alu_op), .src1(ra_data), .src2(alu_src2),
		.result(alu_result), .overflow(alu_overflow), .alu_zero(alu_zero)
	);

	pc_unit #(.IM_ADDR_W(IM_ADDR_W)) u_pc_unit (
		.enable_memaccess(enable_memaccess), .rst(rst), .execute_en(execute_en),
		.pc_sel(pc_sel), .imms(imms), .current_pc(im_address)
	);

endmodule

// File: pc_unit.sv
`timescale 1ns/1ns

module pc_unit #(
	parameter int IM_ADDR_W = 10
) (
	input  logic                      enable_memaccess,
	input  logic                      rst,
	input  logic                      execute_en,
	input  cpu_ctrl_pkg::pc_sel_e     pc_sel,
	input  cpu_ctrl_pkg::imm_fields_t imms,
	output logic [IM_ADDR_W-1:0]      current_pc
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	word_t offset;

	// offsets count instructions from the current pc
	always_comb begin
		case (pc_sel)
			PC_BRANCH: offset = {{18{imms.imm14[13]}}, imms.imm14};
			PC_JUMP:   offset = {{8{imms.imm24[23]}}, imms.imm24};
			default:   offset = 32'd1;
		endcase
	end

	// wraps at the address width
	always_ff @(posedge enable_memaccess) begin
		if (rst)
			current_pc <= '0;
		else if (execute_en)
			current_pc <= current_pc + offset[IM_ADDR_W-1:0];
	end

endmodule

// File: operand_select.sv
`timescale 1ns/1ns

module operand_select (
	input  cpu_isa_pkg::word_t        rb_data,
	input  cpu_ctrl_pkg::imm_fields_t imms,
	input  cpu_ctrl_pkg::imm_sel_e    imm_sel,
	input  cpu_ctrl_pkg::src2_sel_e   src2_sel,
	input  cpu_ctrl_pkg::wb_sel_e     wb_sel,
	input  cpu_isa_pkg::word_t        alu_result,
	input  cpu_isa_pkg::word_t        dm_out,
	output cpu_isa_pkg::word_t        alu_src2,
	output cpu_isa_pkg::word_t        wb_data
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	word_t imm_ext;

	always_comb begin
		case (imm_sel)
			IMM5_ZE:  imm_ext = {27'b0, imms.imm5};
			IMM15_SE: imm_ext = {{17{imms.imm15[14]}}, imms.imm15};
			IMM15_ZE: imm_ext = {17'b0, imms.imm15};
			IMM20_SE: imm_ext = {{12{imms.imm20[19]}}, imms.imm20};
			default:  imm_ext = '0;
		endcase
	end

	assign alu_src2 = (src2_sel == SRC2_IMM) ? imm_ext : rb_data;

	// load data arrives straight from the memory port
	assign wb_data = (wb_sel == WB_MEM) ? dm_out : alu_result;

endmodule

// File: controller.sv
`timescale 1ns/1ns

module controller #(
	parameter int IM_ADDR_W = 10
) (
	input  logic                      enable_memaccess,
	input  logic                      rst,
	input  cpu_isa_pkg::instr_t       instruction,
	input  logic                      alu_zero,
	output logic                      fetch_en,
	output logic                      decode_en,
	output logic                      execute_en,
	output logic                      memaccess_en,
	output logic                      writeback_en,
	output cpu_ctrl_pkg::exec_ctrl_t  ctrl,
	output cpu_ctrl_pkg::imm_fields_t imms,
	output cpu_isa_pkg::reg_addr_t    ra_addr,
	output cpu_isa_pkg::reg_addr_t    rb_addr,
	output cpu_isa_pkg::reg_addr_t    rt_addr,
	output cpu_ctrl_pkg::pc_sel_e     pc_sel
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	stage_e     stage;
	stage_e     stage_next;
	instr_t     ir;
	opcode_t    opcode;
	sub_op_t    sub_op;
	exec_ctrl_t dec_ctrl;

	// pc offsets are taken from a data word
	if (IM_ADDR_W < 1 || IM_ADDR_W > $bits(word_t)) begin : g_im_width_check
		$error("controller: IM_ADDR_W must fit in a data word");
	end

	always_comb begin
		case (stage)
			STAGE_FETCH:     stage_next = STAGE_DECODE;
			STAGE_DECODE:    stage_next = STAGE_EXECUTE;
			STAGE_EXECUTE:   stage_next = STAGE_MEMACCESS;
			STAGE_MEMACCESS: stage_next = STAGE_WRITEBACK;
			default:         stage_next = STAGE_FETCH;
		endcase
	end

	always_ff @(posedge enable_memaccess) begin
		if (rst)
			stage <= STAGE_FETCH;
		else
			stage <= stage_next;
	end

	// nothing is enabled while in reset
	assign fetch_en     = !rst && (stage == STAGE_FETCH);
	assign decode_en    = (stage == STAGE_DECODE);
	assign execute_en   = (stage == STAGE_EXECUTE);
	assign memaccess_en = (stage == STAGE_MEMACCESS);
	assign writeback_en = (stage == STAGE_WRITEBACK);

	always_ff @(posedge enable_memaccess) begin
		if (fetch_en)
			ir <= instruction;
	end

	assign opcode  = ir[30:25];
	assign sub_op  = ir[4:0];
	assign rt_addr = ir[24:20];
	assign ra_addr = ir[19:15];
	// branches compare rt against ra
	assign rb_addr = (opcode == OP_BR1) ? ir[24:20] : ir[14:10];

	always_comb begin
		dec_ctrl = CTRL_NOP;
		case (opcode)
			OP_ALU: begin
				dec_ctrl.reg_write = 1'b1;
				case (sub_op)
					SUB_ADD: dec_ctrl.alu_op = ALU_ADD;
					SUB_SUB: dec_ctrl.alu_op = ALU_SUB;
					SUB_AND: dec_ctrl.alu_op = ALU_AND;
					SUB_OR:  dec_ctrl.alu_op = ALU_OR;
					SUB_XOR: dec_ctrl.alu_op = ALU_XOR;
					SUB_SLLI: begin
						dec_ctrl.alu_op = ALU_SLL;
						dec_ctrl.src2_sel = SRC2_IMM;
					end
					SUB_SRLI: begin
						dec_ctrl.alu_op = ALU_SRL;
						dec_ctrl.src2_sel = SRC2_IMM;
					end
					default: dec_ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				dec_ctrl.src2_sel = SRC2_IMM;
				dec_ctrl.imm_sel = IMM15_SE;
				dec_ctrl.reg_write = 1'b1;
			end
			OP_ORI: begin
				dec_ctrl.alu_op = ALU_OR;
				dec_ctrl.src2_sel = SRC2_IMM;
				dec_ctrl.imm_sel = IMM15_ZE;
				dec_ctrl.reg_write = 1'b1;
			end
			OP_MOVI: begin
				dec_ctrl.alu_op = ALU_PASS_B;
				dec_ctrl.src2_sel = SRC2_IMM;
				dec_ctrl.imm_sel = IMM20_SE;
				dec_ctrl.reg_write = 1'b1;
			end
			OP_LWI: begin
				dec_ctrl.src2_sel = SRC2_IMM;
				dec_ctrl.imm_sel = IMM15_SE;
				dec_ctrl.wb_sel = WB_MEM;
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.dm_read = 1'b1;
			end
			OP_SWI: begin
				dec_ctrl.src2_sel = SRC2_IMM;
				dec_ctrl.imm_sel = IMM15_SE;
				dec_ctrl.dm_write = 1'b1;
			end
			OP_BR1: begin
				dec_ctrl.alu_op = ALU_SUB;
				dec_ctrl.branch_eq = ~ir[BR_NE_BIT];
				dec_ctrl.branch_ne = ir[BR_NE_BIT];
			end
			OP_J: dec_ctrl.jump = ~ir[J_LINK_BIT];
			default: dec_ctrl = CTRL_NOP;
		endcase
	end

	always_ff @(posedge enable_memaccess) begin
		if (rst)
			ctrl <= CTRL_NOP;
		else if (decode_en)
			ctrl <= dec_ctrl;
	end

	always_ff @(posedge enable_memaccess) begin
		if (decode_en)
			imms <= '{imm5: ir[14:10], imm14: ir[13:0], imm15: ir[14:0],
				imm20: ir[19:0], imm24: ir[23:0]};
	end

	// only sampled by the pc in execute
	always_comb begin
		pc_sel = PC_SEQ;
		if (ctrl.jump)
			pc_sel = PC_JUMP;
		else if ((ctrl.branch_eq && alu_zero) || (ctrl.branch_ne && !alu_zero))
			pc_sel = PC_BRANCH;
	end

	a_one_stage: assert property (@(posedge enable_memaccess) disable iff (rst)
		$onehot({fetch_en, decode_en, execute_en, memaccess_en, writeback_en}));

	a_dm_exclusive: assert property (@(posedge enable_memaccess) disable iff (rst)
		memaccess_en |-> !(ctrl.dm_read && ctrl.dm_write));

endmodule

// File: regfile.sv
`timescale 1ns/1ns

module regfile (
	input  logic                   enable_memaccess,
	input  logic                   rst,
	input  logic                   writeback_en,
	input  logic                   reg_write,
	input  cpu_isa_pkg::reg_addr_t ra_addr,
	input  cpu_isa_pkg::reg_addr_t rb_addr,
	input  cpu_isa_pkg::reg_addr_t rt_addr,
	input  cpu_isa_pkg::word_t     wb_data,
	output cpu_isa_pkg::word_t     ra_data,
	output cpu_isa_pkg::word_t     rb_data,
	output cpu_isa_pkg::word_t     rt_data
);
	import cpu_isa_pkg::*;

	word_t regs [32];

	// r0 is a normal register here
	always_ff @(posedge enable_memaccess) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeback_en && reg_write) begin
			regs[rt_addr] <= wb_data;
		end
	end

	// rt is also read as the store data
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

// File: alu.sv
`timescale 1ns/1ns

module alu #(
	parameter int DM_ADDR_W = 12
) (
	input  logic                   enable_memaccess,
	input  logic                   rst,
	input  logic                   execute_en,
	input  cpu_ctrl_pkg::alu_op_e  alu_op,
	input  cpu_isa_pkg::word_t     src1,
	input  cpu_isa_pkg::word_t     src2,
	output cpu_isa_pkg::word_t     result,
	output logic                   overflow,
	output logic                   alu_zero
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	word_t result_c;
	logic  overflow_c;

	// the latched result doubles as the data memory word address
	if (DM_ADDR_W < 1 || DM_ADDR_W > $bits(word_t)) begin : g_dm_width_check
		$error("alu: DM_ADDR_W must fit in a data word");
	end

	always_comb begin
		result_c = src2;
		overflow_c = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				result_c = src1 + src2;
				overflow_c = (src1[31] == src2[31]) && (result_c[31] != src1[31]);
			end
			ALU_SUB: begin
				result_c = src1 - src2;
				overflow_c = (src1[31] != src2[31]) && (result_c[31] != src1[31]);
			end
			ALU_AND:    result_c = src1 & src2;
			ALU_OR:     result_c = src1 | src2;
			ALU_XOR:    result_c = src1 ^ src2;
			ALU_SLL:    result_c = src1 << src2[4:0];
			ALU_SRL:    result_c = src1 >> src2[4:0];
			ALU_PASS_B: result_c = src2;
			default:    result_c = src2;
		endcase
	end

	// branch compare uses SUB, so zero means equal operands
	assign alu_zero = (result_c == '0);

	always_ff @(posedge enable_memaccess) begin
		if (execute_en)
			result <= result_c;
	end

	always_ff @(posedge enable_memaccess) begin
		if (rst)
			overflow <= 1'b0;
		else if (execute_en)
			overflow <= overflow_c;
	end

	a_overflow_after_execute: assert property (@(posedge enable_memaccess) disable iff (rst)
		$rose(overflow) |-> $past(execute_en && (alu_op == ALU_ADD || alu_op == ALU_SUB)));

endmodule

// File: cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	typedef enum logic [2:0] {
		STAGE_FETCH,
		STAGE_DECODE,
		STAGE_EXECUTE,
		STAGE_MEMACCESS,
		STAGE_WRITEBACK
	} stage_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic {SRC2_RB, SRC2_IMM} src2_sel_e;
	typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;
	typedef enum logic [1:0] {IMM5_ZE, IMM15_SE, IMM15_ZE, IMM20_SE} imm_sel_e;
	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP} pc_sel_e;

	typedef struct packed {
		alu_op_e   alu_op;
		src2_sel_e src2_sel;
		imm_sel_e  imm_sel;
		wb_sel_e   wb_sel;
		logic      reg_write;
		logic      dm_read;
		logic      dm_write;
		logic      branch_eq;
		logic      branch_ne;
		logic      jump;
	} exec_ctrl_t;

	typedef struct packed {
		cpu_isa_pkg::imm5_t  imm5;
		cpu_isa_pkg::imm14_t imm14;
		cpu_isa_pkg::imm15_t imm15;
		cpu_isa_pkg::imm20_t imm20;
		cpu_isa_pkg::imm24_t imm24;
	} imm_fields_t;

	// no-op that writes nothing anywhere
	localparam exec_ctrl_t CTRL_NOP = '{
		alu_op:    ALU_ADD,
		src2_sel:  SRC2_RB,
		imm_sel:   IMM5_ZE,
		wb_sel:    WB_ALU,
		reg_write: 1'b0,
		dm_read:   1'b0,
		dm_write:  1'b0,
		branch_eq: 1'b0,
		branch_ne: 1'b0,
		jump:      1'b0
	};

endpackage

// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

	// basic widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [4:0]  sub_op_t;

	// raw 32-bit instruction word
	typedef logic [31:0] instr_t;

	// immediate fields as they sit in the instruction
	typedef logic [4:0]  imm5_t;
	typedef logic [13:0] imm14_t;
	typedef logic [14:0] imm15_t;
	typedef logic [19:0] imm20_t;
	typedef logic [23:0] imm24_t;

	// major opcodes in instruction bits [30:25]
	localparam opcode_t OP_LWI  = 6'b000010;
	localparam opcode_t OP_SWI  = 6'b001010;
	localparam opcode_t OP_ALU  = 6'b100000;
	localparam opcode_t OP_MOVI = 6'b100010;
	localparam opcode_t OP_J    = 6'b100100;
	localparam opcode_t OP_BR1  = 6'b100110;
	localparam opcode_t OP_ADDI = 6'b101000;
	localparam opcode_t OP_ORI  = 6'b101100;

	// alu sub-ops in instruction bits [4:0] under OP_ALU
	localparam sub_op_t SUB_ADD  = 5'b00000;
	localparam sub_op_t SUB_SUB  = 5'b00001;
	localparam sub_op_t SUB_AND  = 5'b00010;
	localparam sub_op_t SUB_XOR  = 5'b00011;
	localparam sub_op_t SUB_OR   = 5'b00100;
	localparam sub_op_t SUB_SLLI = 5'b01000;
	localparam sub_op_t SUB_SRLI = 5'b01001;

	// BR1 picks BNE when this bit is set, BEQ otherwise
	localparam int BR_NE_BIT = 14;

	// set for JAL, which is not implemented
	localparam int J_LINK_BIT = 24;

	// memory offsets count words, not bytes

endpackage
